//--- filelist.f
+incdir+.
rt_list_pkg.sv
leaf_max_store.sv
hit_record_store.sv
hit_resolve_pipe.sv
result_fifo.sv
list_unit.sv
list_unit_properties.sv
list_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the list unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module list_unit_tb -o list_unit_sim

./obj_dir/list_unit_sim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation did not pass"
  exit 1
fi

//--- list_unit_tb.sv
/*
  ray list unit testbench
  rounds of leaf writes and triangle results on alternating ray pools,
  a shadow model of the per-ray records, and a checker on both outputs
  under random back-pressure
*/
`timescale 1ns/1ps
`default_nettype none

`include "rt_list_cfg.svh"

module list_unit_tb;

  localparam int NUM_RAYS = 1 << `RT_RAY_ID_W;
  localparam int RAYS = 8; // rays per pool
  localparam int NUM_ROUNDS = 12;

  logic clk = 1'b0;
  logic arst_n;
  logic trav0_valid, trav1_valid, int_valid;
  rt_list_pkg::trav_to_list_t trav0_data, trav1_data;
  rt_list_pkg::int_to_list_t int_data;
  logic trav0_stall, trav1_stall, int_stall;
  logic rs_valid, ss_valid;
  rt_list_pkg::list_to_rs_t rs_data;
  rt_list_pkg::list_to_ss_t ss_data;
  logic rs_stall = 1'b0;
  logic ss_stall = 1'b0;

  // shadow state of the unit
  rt_list_pkg::float_t t_max_ref [NUM_RAYS];
  logic hit_ref [NUM_RAYS];
  rt_list_pkg::hit_rec_t rec_ref [NUM_RAYS];
  rt_list_pkg::list_to_rs_t exp_rs [$];
  rt_list_pkg::list_to_ss_t exp_ss [$];
  int rs_idx = 0; // next expected item per stream
  int ss_idx = 0;
  int n_sent = 0;
  int cycles = 0;
  int stall_pct = 0; // output stall chance in percent
  logic read_due = 1'b0; // port A busy with a pipeline read this cycle

  always #4 clk = ~clk; // 8 ns period

  list_unit dut_i (
    .clk, .arst_n,
    .trav0_to_list_valid(trav0_valid), .trav0_to_list_data(trav0_data),
    .trav0_to_list_stall(trav0_stall),
    .trav1_to_list_valid(trav1_valid), .trav1_to_list_data(trav1_data),
    .trav1_to_list_stall(trav1_stall),
    .int_to_list_valid(int_valid), .int_to_list_data(int_data),
    .int_to_list_stall(int_stall),
    .list_to_rs_valid(rs_valid), .list_to_rs_data(rs_data), .list_to_rs_stall(rs_stall),
    .list_to_ss_valid(ss_valid), .list_to_ss_data(ss_data), .list_to_ss_stall(ss_stall)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  // pools differ in the low bit, so one can be rewritten while the other resolves
  function automatic rt_list_pkg::ray_id_t ray_of(input int pool, input int k);
    return rt_list_pkg::ray_id_t'(k * 64 + pool * 33);
  endfunction

  // narrow range so ties and hits past the leaf both show up
  function automatic rt_list_pkg::float_t rand_dist();
    return 32'h4120_0000 + $urandom_range(0, 255);
  endfunction

  // ------------------------------------------------
  // reference model, 0 nothing, 1 hit out, 2 miss out
  // ------------------------------------------------
  function automatic int model_result(input rt_list_pkg::int_to_list_t it,
                                      output rt_list_pkg::list_to_rs_t rs_item,
                                      output rt_list_pkg::list_to_ss_t ss_item);
    rt_list_pkg::ray_id_t r;
    logic best;
    r = it.ray_id;
    rs_item = '0;
    ss_item = '0;
    best = hit_ref[r] || it.hit;
    if (it.hit && (!hit_ref[r] || it.t_int < rec_ref[r].t)) begin // strictly nearer
      rec_ref[r].tri_id = it.tri_id;
      rec_ref[r].uv = it.uv;
      rec_ref[r].t = it.t_int;
    end
    hit_ref[r] = best;
    if (!it.is_last) begin
      return 0;
    end
    if (best && rec_ref[r].t <= t_max_ref[r]) begin
      rs_item.ray_id = r;
      rs_item.tri_id = rec_ref[r].tri_id;
      rs_item.uv = rec_ref[r].uv;
      rs_item.t = rec_ref[r].t;
      hit_ref[r] = 1'b0; // shaded, next leaf starts clean
      return 1;
    end
    ss_item.ray_id = r; // hit past the leaf stays stored
    return 2;
  endfunction

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  task automatic send_leaves(input int pool);
    rt_list_pkg::float_t t0, t1;
    for (int k = 0; k < RAYS; k += 2) begin
      t0 = rand_dist();
      t1 = rand_dist();
      @(negedge clk);
      trav0_valid = 1'b1;
      trav0_data.ray_id = ray_of(pool, k);
      trav0_data.t_max = t0;
      trav1_valid = 1'b1;
      trav1_data.ray_id = ray_of(pool, k + 1);
      trav1_data.t_max = t1;
      t_max_ref[ray_of(pool, k + 1)] = t1; // port B always takes it
      while (trav0_stall) begin // pipeline read owns port A
        @(negedge clk);
        trav1_valid = 1'b0;
      end
      t_max_ref[ray_of(pool, k)] = t0;
    end
    @(negedge clk);
    trav0_valid = 1'b0;
    trav1_valid = 1'b0;
  endtask

  task automatic send_results(input int pool);
    int left [RAYS];
    int total, cur, kind;
    rt_list_pkg::int_to_list_t it;
    rt_list_pkg::list_to_rs_t rs_item;
    rt_list_pkg::list_to_ss_t ss_item;
    total = 0;
    for (int k = 0; k < RAYS; k++) begin
      left[k] = $urandom_range(1, 6);
      total += left[k];
    end
    cur = $urandom_range(0, RAYS - 1);
    while (total > 0) begin
      // staying on one ray gives back-to-back results for forwarding
      if (left[cur] == 0 || $urandom_range(0, 1) == 0) begin
        do begin
          cur = $urandom_range(0, RAYS - 1);
        end while (left[cur] == 0);
      end
      left[cur]--;
      total--;
      it.ray_id = ray_of(pool, cur);
      it.tri_id = rt_list_pkg::tri_id_t'($urandom());
      it.uv = $urandom();
      it.t_int = rand_dist();
      it.hit = ($urandom_range(0, 2) != 0);
      it.is_last = (left[cur] == 0);
      @(negedge clk);
      if ($urandom_range(0, 3) == 0) begin
        int_valid = 1'b0; // spaced results now and then
        @(negedge clk);
      end
      int_valid = 1'b1;
      int_data = it;
      while (int_stall) @(negedge clk);
      kind = model_result(it, rs_item, ss_item);
      if (kind == 1) exp_rs.push_back(rs_item);
      else if (kind == 2) exp_ss.push_back(ss_item);
      n_sent++;
    end
    @(negedge clk);
    int_valid = 1'b0;
  endtask

  // a result taken at this edge is read from port A in the next cycle
  always @(posedge clk) begin
    read_due <= arst_n && int_valid && !int_stall;
  end

  // ------------------------------------------------
  // output stall and compare, both settled at negedge
  // ------------------------------------------------
  always @(negedge clk) begin
    rs_stall = ($urandom_range(0, 99) < stall_pct);
    ss_stall = ($urandom_range(0, 99) < stall_pct);
    if (arst_n) begin
      check_value("trav0_stall", 128'(read_due), 128'(trav0_stall));
    end
    if (arst_n && rs_valid && !rs_stall) begin
      if (rs_idx >= exp_rs.size()) fail_run("hit output arrived with no hit expected");
      else begin
        check_value("hit_item", 128'(exp_rs[rs_idx]), 128'(rs_data));
        rs_idx++;
      end
    end
    if (arst_n && ss_valid && !ss_stall) begin
      if (ss_idx >= exp_ss.size()) fail_run("miss output arrived with no miss expected");
      else begin
        check_value("miss_item", 128'(exp_ss[ss_idx]), 128'(ss_data));
        ss_idx++;
      end
    end
  end

  // limit grows with the traffic sent
  always @(posedge clk) begin
    cycles++;
    if (cycles > 20 * n_sent + 200) begin
      fail_run("outputs never arrived within the cycle limit");
    end
  end

  initial begin
    void'($urandom(92990));
    arst_n = 1'b0;
    trav0_valid = 1'b0;
    trav1_valid = 1'b0;
    int_valid = 1'b0;
    trav0_data = '0;
    trav1_data = '0;
    int_data = '0;
    for (int i = 0; i < NUM_RAYS; i++) begin
      hit_ref[i] = 1'b0; // reset clears every flag
      t_max_ref[i] = '0;
      rec_ref[i] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_value("reset_trav0_stall", 128'(0), 128'(trav0_stall));
    check_value("reset_int_stall", 128'(0), 128'(int_stall));
    arst_n = 1'b1;

    send_leaves(0);
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      stall_pct = (r % 2 == 1) ? 70 : 20;
      fork
        send_results(r % 2);
        if (r + 1 < NUM_ROUNDS) send_leaves((r + 1) % 2); // writes during reads
      join
      repeat (4) @(negedge clk); // last reads of this pool done
    end

    while (rs_idx < exp_rs.size() || ss_idx < exp_ss.size()) @(negedge clk);
    repeat (20) @(negedge clk); // catch stray extra outputs
    // drained unit holds nothing and takes input again
    if (!rs_valid && !ss_valid && !int_stall) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run("outputs left over or input still stalled after the drain");
    end
  end

endmodule

`default_nettype wire

//--- list_unit_properties.sv
/*
  list unit port properties
  reset quiet outputs, held payload under stall, port B never stalled
*/
`timescale 1ns/1ps
`default_nettype none

module list_unit_properties (
  input logic clk,
  input logic arst_n,
  input logic list_to_rs_valid,
  input rt_list_pkg::list_to_rs_t list_to_rs_data,
  input logic list_to_rs_stall,
  input logic list_to_ss_valid,
  input rt_list_pkg::list_to_ss_t list_to_ss_data,
  input logic list_to_ss_stall,
  input logic trav1_to_list_stall
);

  // ------------------------------------------------
  // outputs
  // ------------------------------------------------
  rs_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !list_to_rs_valid)
    else $error("hit output valid during reset");
  ss_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !list_to_ss_valid)
    else $error("miss output valid during reset");

  rs_held: assert property (@(posedge clk) disable iff (!arst_n)
    (list_to_rs_valid && list_to_rs_stall) |=> (list_to_rs_valid && $stable(list_to_rs_data)))
    else $error("hit output changed while stalled");
  ss_held: assert property (@(posedge clk) disable iff (!arst_n)
    (list_to_ss_valid && list_to_ss_stall) |=> (list_to_ss_valid && $stable(list_to_ss_data)))
    else $error("miss output changed while stalled");

  // traversal port B owns its write port
  trav1_free: assert property (@(posedge clk) !trav1_to_list_stall)
    else $error("traversal port 1 stalled");

endmodule

bind list_unit list_unit_properties props_i (.*);

`default_nettype wire

//--- list_unit.sv
/*
  ray list unit
  keeps the leaf far distance and best hit per ray, resolves every
  intersection result and emits definite hits and misses
*/
`timescale 1ns/1ps
`default_nettype none

`include "rt_list_cfg.svh"

module list_unit (
  input  logic clk,
  input  logic arst_n,

  input  logic trav0_to_list_valid,
  input  rt_list_pkg::trav_to_list_t trav0_to_list_data,
  output logic trav0_to_list_stall,

  input  logic trav1_to_list_valid,
  input  rt_list_pkg::trav_to_list_t trav1_to_list_data,
  output logic trav1_to_list_stall,

  input  logic int_to_list_valid,
  input  rt_list_pkg::int_to_list_t int_to_list_data,
  output logic int_to_list_stall,

  output logic list_to_rs_valid,
  output rt_list_pkg::list_to_rs_t list_to_rs_data,
  input  logic list_to_rs_stall,

  output logic list_to_ss_valid,
  output rt_list_pkg::list_to_ss_t list_to_ss_data,
  input  logic list_to_ss_stall
);

  logic leaf_rd_en, rec_rd_en, rec_hit, rec_wr_en, rec_wr_hit;
  rt_list_pkg::ray_id_t leaf_rd_ray_id, rec_rd_ray_id, rec_wr_ray_id;
  rt_list_pkg::float_t leaf_t_max;
  rt_list_pkg::hit_rec_t rec, rec_wr;
  logic rs_push, ss_push;
  rt_list_pkg::list_to_rs_t rs_data;
  rt_list_pkg::list_to_ss_t ss_data;
  logic [2:0] rs_free, ss_free;

  // ------------------------------------------------
  // stores
  // ------------------------------------------------
  leaf_max_store leaf_max_i (
    .clk, .arst_n,
    .rd_en(leaf_rd_en), .rd_ray_id(leaf_rd_ray_id), .rd_t_max(leaf_t_max),
    .trav0_valid(trav0_to_list_valid), .trav0_data(trav0_to_list_data),
    .trav0_stall(trav0_to_list_stall),
    .trav1_valid(trav1_to_list_valid), .trav1_data(trav1_to_list_data),
    .trav1_stall(trav1_to_list_stall)
  );

  hit_record_store hit_rec_i (
    .clk, .arst_n,
    .rd_en(rec_rd_en), .rd_ray_id(rec_rd_ray_id), .rd_hit(rec_hit), .rd_rec(rec),
    .wr_en(rec_wr_en), .wr_ray_id(rec_wr_ray_id), .wr_hit(rec_wr_hit), .wr_rec(rec_wr)
  );

  // ------------------------------------------------
  // resolve pipeline
  // ------------------------------------------------
  hit_resolve_pipe pipe_i (
    .clk, .arst_n,
    .in_valid(int_to_list_valid), .in_data(int_to_list_data),
    .in_stall(int_to_list_stall),
    .leaf_rd_en, .leaf_rd_ray_id, .leaf_t_max,
    .rec_rd_en, .rec_rd_ray_id, .rec_hit, .rec,
    .rec_wr_en, .rec_wr_ray_id, .rec_wr_hit, .rec_wr,
    .rs_push, .rs_data, .ss_push, .ss_data,
    .rs_free, .ss_free
  );

  // ------------------------------------------------
  // output buffers, hits to shader and misses to scheduler
  // ------------------------------------------------
  result_fifo #(
    .WIDTH($bits(rt_list_pkg::list_to_rs_t)), .DEPTH(`RT_OUT_FIFO_DEPTH)
  ) rs_fifo_i (
    .clk, .arst_n,
    .push(rs_push), .push_data(rs_data), .free(rs_free),
    .out_valid(list_to_rs_valid), .out_data(list_to_rs_data),
    .out_stall(list_to_rs_stall)
  );

  result_fifo #(
    .WIDTH($bits(rt_list_pkg::list_to_ss_t)), .DEPTH(`RT_OUT_FIFO_DEPTH)
  ) ss_fifo_i (
    .clk, .arst_n,
    .push(ss_push), .push_data(ss_data), .free(ss_free),
    .out_valid(list_to_ss_valid), .out_data(list_to_ss_data),
    .out_stall(list_to_ss_stall)
  );

endmodule

`default_nettype wire

//--- result_fifo.sv
/*
  result fifo
  small circular buffer with valid/stall output. the producer checks
  free before pushing, so there is no full flag
*/
`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n,

  input  logic push,
  input  logic [WIDTH-1:0] push_data,
  output logic [2:0] free,

  output logic out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic out_stall
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic pop;

  assign pop = out_valid && !out_stall;
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr]; // head, held while stalled
  assign free = 3'(DEPTH - count);

  // ------------------------------------------------
  // pointers and count
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop); // both at once nets to zero
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- hit_resolve_pipe.sv
/*
  hit resolve pipeline
  s0 reads both stores, s1 picks the nearer hit and makes the end of
  leaf call, s2 writes the record back and pushes hit or miss.
  same-ray results in flight are forwarded from s2 and the last write
*/
`timescale 1ns/1ps
`default_nettype none

module hit_resolve_pipe (
  input  logic clk,
  input  logic arst_n,

  input  logic in_valid,
  input  rt_list_pkg::int_to_list_t in_data,
  output logic in_stall,

  output logic leaf_rd_en,
  output rt_list_pkg::ray_id_t leaf_rd_ray_id,
  input  rt_list_pkg::float_t leaf_t_max,

  output logic rec_rd_en,
  output rt_list_pkg::ray_id_t rec_rd_ray_id,
  input  logic rec_hit,
  input  rt_list_pkg::hit_rec_t rec,

  output logic rec_wr_en,
  output rt_list_pkg::ray_id_t rec_wr_ray_id,
  output logic rec_wr_hit,
  output rt_list_pkg::hit_rec_t rec_wr,

  output logic rs_push,
  output rt_list_pkg::list_to_rs_t rs_data,
  output logic ss_push,
  output rt_list_pkg::list_to_ss_t ss_data,

  input  logic [2:0] rs_free,
  input  logic [2:0] ss_free
);

  // what one item writes back
  typedef struct packed {
    rt_list_pkg::ray_id_t ray_id;
    logic hit;
    rt_list_pkg::hit_rec_t rec;
  } wb_t;

  logic s0_valid, s1_valid, s2_valid, wb_valid;
  rt_list_pkg::int_to_list_t s0_data, s1_data;
  wb_t s1_wb, s2_wb, wb_q;
  logic s1_last, s1_to_rs, s2_last, s2_to_rs;

  logic accept;
  logic [2:0] in_flight;
  logic cur_hit, take_new, best_hit;
  rt_list_pkg::hit_rec_t cur_rec;

  // ------------------------------------------------
  // credit check
  // ------------------------------------------------
  // every item in flight may push, so keep that many slots plus one
  assign in_flight = 3'(s0_valid) + 3'(s1_valid) + 3'(s2_valid);
  assign in_stall = (rs_free <= in_flight) || (ss_free <= in_flight);
  assign accept = in_valid && !in_stall;

  // s0 issues the reads
  assign leaf_rd_en = s0_valid;
  assign leaf_rd_ray_id = s0_data.ray_id;
  assign rec_rd_en = s0_valid;
  assign rec_rd_ray_id = s0_data.ray_id;

  // ------------------------------------------------
  // s1 forward and decide
  // ------------------------------------------------
  always_comb begin
    cur_hit = rec_hit;
    cur_rec = rec;
    if (s2_valid && s2_wb.ray_id == s1_data.ray_id) begin
      cur_hit = s2_wb.hit; // writes at the end of this cycle
      cur_rec = s2_wb.rec;
    end else if (wb_valid && wb_q.ray_id == s1_data.ray_id) begin
      cur_hit = wb_q.hit; // written as our read went out
      cur_rec = wb_q.rec;
    end

    // strictly nearer replaces, ties keep the older hit
    take_new = s1_data.hit && (!cur_hit || (s1_data.t_int < cur_rec.t));
    best_hit = cur_hit || s1_data.hit;

    s1_wb.ray_id = s1_data.ray_id;
    s1_wb.rec = cur_rec;
    if (take_new) begin
      s1_wb.rec.tri_id = s1_data.tri_id;
      s1_wb.rec.uv = s1_data.uv;
      s1_wb.rec.t = s1_data.t_int;
    end

    s1_last = s1_data.is_last;
    // unsigned compare is enough for non-negative floats
    s1_to_rs = s1_last && best_hit && (s1_wb.rec.t <= leaf_t_max);
    s1_wb.hit = best_hit && !s1_to_rs; // shading a hit clears the flag
  end

  // ------------------------------------------------
  // stage valids
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      s0_valid <= accept;
      s1_valid <= s0_valid;
      s2_valid <= s1_valid;
      wb_valid <= s2_valid; // last write, kept for forwarding
    end
  end

  // payload, never stalls once accepted
  always_ff @(posedge clk) begin
    if (accept) begin
      s0_data <= in_data;
    end
    s1_data <= s0_data;
    s2_wb <= s1_wb;
    s2_last <= s1_last;
    s2_to_rs <= s1_to_rs;
    wb_q <= s2_wb;
  end

  // ------------------------------------------------
  // s2 write back and push
  // ------------------------------------------------
  assign rec_wr_en = s2_valid;
  assign rec_wr_ray_id = s2_wb.ray_id;
  assign rec_wr_hit = s2_wb.hit;
  assign rec_wr = s2_wb.rec;

  assign rs_push = s2_valid && s2_last && s2_to_rs;
  assign ss_push = s2_valid && s2_last && !s2_to_rs; // incl. hits beyond the leaf
  assign rs_data.ray_id = s2_wb.ray_id;
  assign rs_data.tri_id = s2_wb.rec.tri_id;
  assign rs_data.uv = s2_wb.rec.uv;
  assign rs_data.t = s2_wb.rec.t;
  assign ss_data.ray_id = s2_wb.ray_id;

endmodule

`default_nettype wire

//--- hit_record_store.sv
/*
  hit record store
  best hit so far per ray: tri id, uv and t in an array, hit flag in
  a register vector so reset clears every ray at once
*/
`timescale 1ns/1ps
`default_nettype none

module hit_record_store (
  input  logic clk,
  input  logic arst_n,

  input  logic rd_en,
  input  rt_list_pkg::ray_id_t rd_ray_id,
  output logic rd_hit,
  output rt_list_pkg::hit_rec_t rd_rec,

  input  logic wr_en,
  input  rt_list_pkg::ray_id_t wr_ray_id,
  input  logic wr_hit,
  input  rt_list_pkg::hit_rec_t wr_rec
);

  localparam int NUM_RAYS = 1 << $bits(rt_list_pkg::ray_id_t);

  rt_list_pkg::hit_rec_t mem [NUM_RAYS];
  logic [NUM_RAYS-1:0] hit_flags; // one bit per ray

  // ------------------------------------------------
  // hit flags
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_flags <= '0;
      rd_hit <= 1'b0;
    end else begin
      if (rd_en) begin
        rd_hit <= hit_flags[rd_ray_id]; // old value on same-cycle write
      end
      if (wr_en) begin
        hit_flags[wr_ray_id] <= wr_hit;
      end
    end
  end

  // ------------------------------------------------
  // record array
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ray_id] <= wr_rec;
    end
    if (rd_en) begin
      rd_rec <= mem[rd_ray_id]; // read first, pipeline forwards around it
    end
  end

endmodule

`default_nettype wire

//--- leaf_max_store.sv
/*
  leaf max store
  per-ray far distance of the current leaf in a dual-port array.
  port A: pipeline read, else traversal 0 write. port B: traversal 1 write
*/
`timescale 1ns/1ps
`default_nettype none

module leaf_max_store (
  input  logic clk,
  input  logic arst_n,

  input  logic rd_en,
  input  rt_list_pkg::ray_id_t rd_ray_id,
  output rt_list_pkg::float_t rd_t_max,

  input  logic trav0_valid,
  input  rt_list_pkg::trav_to_list_t trav0_data,
  output logic trav0_stall,

  input  logic trav1_valid,
  input  rt_list_pkg::trav_to_list_t trav1_data,
  output logic trav1_stall
);

  localparam int NUM_RAYS = 1 << $bits(rt_list_pkg::ray_id_t);

  rt_list_pkg::float_t mem [NUM_RAYS];
  rt_list_pkg::float_t rd_q;

  logic wr_a, wr_b;

  // reading always wins port A, trav0 has to wait it out
  assign trav0_stall = rd_en;
  assign wr_a = trav0_valid && !rd_en;
  assign wr_b = trav1_valid; // port B is trav1's alone
  assign trav1_stall = 1'b0;

  // ------------------------------------------------
  // array, both write ports
  // ------------------------------------------------
  // traffic never puts the same ray on both ports in one cycle
  always_ff @(posedge clk) begin
    if (wr_a) begin
      mem[trav0_data.ray_id] <= trav0_data.t_max;
    end
    if (wr_b) begin
      mem[trav1_data.ray_id] <= trav1_data.t_max;
    end
  end

  // ------------------------------------------------
  // port A read, one cycle
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= '0; // output register aclr
    end else if (rd_en) begin
      rd_q <= mem[rd_ray_id];
    end
  end

  assign rd_t_max = rd_q;

endmodule

`default_nettype wire

//--- rt_list_pkg.sv
/*
  ray list unit types
  vector typedefs for ids and distances, plus the packed structs
  carried on the traversal, intersection and output ports
*/
`default_nettype none

`include "rt_list_cfg.svh"

package rt_list_pkg;

  typedef logic [`RT_RAY_ID_W-1:0] ray_id_t; // index of a ray record
  typedef logic [`RT_TRI_ID_W-1:0] tri_id_t;
  typedef logic [`RT_UV_W-1:0] bari_uv_t; // {u, v}
  typedef logic [`RT_FLOAT_W-1:0] float_t; // non-negative, compared as unsigned

  // ------------------------------------------------
  // port payloads
  // ------------------------------------------------
  typedef struct packed {
    ray_id_t ray_id;
    float_t t_max; // far end of the new leaf
  } trav_to_list_t;

  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    bari_uv_t uv;
    float_t t_int; // only meaningful when hit is set
    logic hit;
    logic is_last; // last triangle of the leaf
  } int_to_list_t;

  // best hit kept per ray
  typedef struct packed {
    tri_id_t tri_id;
    bari_uv_t uv;
    float_t t;
  } hit_rec_t;

  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    bari_uv_t uv;
    float_t t;
  } list_to_rs_t; // definite hit, off to the shader

  typedef struct packed {
    ray_id_t ray_id;
  } list_to_ss_t; // definite miss, back to the scheduler

endpackage

`default_nettype wire

//--- rt_list_cfg.svh
/*
  ray list unit configuration
  widths of the per-ray record fields and output buffer depth
*/
`ifndef RT_LIST_CFG_SVH
`define RT_LIST_CFG_SVH

// ------------------------------------------------
// record field widths
// ------------------------------------------------
`define RT_RAY_ID_W 9 // 512 rays in flight
`define RT_TRI_ID_W 16 // triangle id
`define RT_UV_W 32 // two 16-bit barycentric coords packed
`define RT_FLOAT_W 32 // ieee-754 single

// ------------------------------------------------
// buffering
// ------------------------------------------------
`define RT_OUT_FIFO_DEPTH 4 // per output stream

`endif
